// ==== design/cpu8_pkg.sv ====
package cpu8_pkg;

	// ====================================================================
	// Encodings
	// ====================================================================

	// Register codes in instruction field order, M is the byte at HL
	typedef enum logic [2:0] {
		REG_B = 3'd0,
		REG_C = 3'd1,
		REG_D = 3'd2,
		REG_E = 3'd3,
		REG_H = 3'd4,
		REG_L = 3'd5,
		REG_M = 3'd6,
		REG_A = 3'd7
	} reg_sel_e;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_ADC = 3'd1,
		ALU_SUB = 3'd2,
		ALU_SBB = 3'd3,
		ALU_AND = 3'd4,
		ALU_XOR = 3'd5,
		ALU_OR  = 3'd6,
		ALU_CMP = 3'd7
	} alu_op_e;

	typedef enum logic [2:0] {
		IC_NOP,
		IC_MOV,
		IC_MVI,
		IC_ALU,
		IC_ALUI,
		IC_JMP,
		IC_JCC,
		IC_HLT
	} instr_class_e;

	typedef enum logic [3:0] {
		ST_FETCH,
		ST_DECODE,
		ST_MOV,
		ST_MVI0,
		ST_MVI1,
		ST_ALU0,
		ST_ALU1,
		ST_JMP0,
		ST_JMP1,
		ST_HALT
	} cpu_state_e;

	// Flag register layout, bit 1 reads as one and bits 5 and 3 as zero
	localparam int FLAG_S  = 7;
	localparam int FLAG_Z  = 6;
	localparam int FLAG_AC = 4;
	localparam int FLAG_P  = 2;
	localparam int FLAG_CY = 0;
	localparam logic [7:0] PSR_FIXED = 8'h02;

	// Opcodes and base patterns, the register or operation fields are ORed in
	localparam logic [7:0] OP_HLT  = 8'h76;
	localparam logic [7:0] OP_JMP  = 8'hC3;
	localparam logic [7:0] OP_MOV  = 8'h40;
	localparam logic [7:0] OP_MVI  = 8'h06;
	localparam logic [7:0] OP_ALU  = 8'h80;
	localparam logic [7:0] OP_ALUI = 8'hC6;
	localparam logic [7:0] OP_JCC  = 8'hC2;

	// Condition codes of the JCC field
	localparam logic [2:0] CC_NZ = 3'd0;
	localparam logic [2:0] CC_Z  = 3'd1;
	localparam logic [2:0] CC_NC = 3'd2;
	localparam logic [2:0] CC_C  = 3'd3;
	localparam logic [2:0] CC_PO = 3'd4;
	localparam logic [2:0] CC_PE = 3'd5;
	localparam logic [2:0] CC_P  = 3'd6;
	localparam logic [2:0] CC_M  = 3'd7;

	// ====================================================================
	// Bundles between units
	// ====================================================================

	typedef struct packed {
		instr_class_e iclass;
		reg_sel_e     dst;
		reg_sel_e     src;
		alu_op_e      alu_op;
		logic         cond_true;
	} decoded_t;

	typedef struct packed {
		logic [7:0] value;
		logic [7:0] flags;
	} alu_result_t;

	typedef struct packed {
		logic        read;
		logic        write;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} bus_req_t;

endpackage

// ==== design/alu8.sv ====
module alu8 (
	input  logic                  [7:0] a,
	input  logic                  [7:0] b,
	input  logic                        carry_in,
	input  cpu8_pkg::alu_op_e           op,
	output cpu8_pkg::alu_result_t       result
);

	logic       cin;
	logic [8:0] wide;
	logic [4:0] nibble;
	logic [7:0] value;
	logic       cy;
	logic       ac;

	// Carry or borrow only enters ADC and SBB
	assign cin = carry_in && (op == cpu8_pkg::ALU_ADC || op == cpu8_pkg::ALU_SBB);

	always_comb begin
		wide = 9'h000;
		nibble = 5'h00;
		value = 8'h00;
		cy = 1'b0;
		ac = 1'b0;
		case (op)
			cpu8_pkg::ALU_ADD, cpu8_pkg::ALU_ADC: begin
				wide = {1'b0, a} + {1'b0, b} + {8'h00, cin};
				nibble = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'h0, cin};
				value = wide[7:0];
				cy = wide[8];
				ac = nibble[4];
			end
			cpu8_pkg::ALU_SUB, cpu8_pkg::ALU_SBB, cpu8_pkg::ALU_CMP: begin
				wide = {1'b0, a} - {1'b0, b} - {8'h00, cin};
				nibble = {1'b0, a[3:0]} - {1'b0, b[3:0]} - {4'h0, cin};
				value = wide[7:0];
				// Carry is the borrow out
				cy = wide[8];
				// AC is set when the low nibble did not borrow
				ac = !nibble[4];
			end
			cpu8_pkg::ALU_AND: begin
				value = a & b;
				ac = a[3] | b[3];
			end
			cpu8_pkg::ALU_XOR: begin
				value = a ^ b;
			end
			cpu8_pkg::ALU_OR: begin
				value = a | b;
			end
		endcase
	end

	// ====================================================================
	// Flag byte
	// ====================================================================

	always_comb begin
		result.value = value;
		result.flags = cpu8_pkg::PSR_FIXED;
		result.flags[cpu8_pkg::FLAG_S] = value[7];
		result.flags[cpu8_pkg::FLAG_Z] = value == 8'h00;
		result.flags[cpu8_pkg::FLAG_AC] = ac;
		// Even parity
		result.flags[cpu8_pkg::FLAG_P] = ~^value;
		result.flags[cpu8_pkg::FLAG_CY] = cy;
	end

endmodule

// ==== design/instr_decoder.sv ====
module instr_decoder (
	input  logic [7:0]         ir,
	input  logic [7:0]         flags,
	output cpu8_pkg::decoded_t decoded
);

	// Masks that keep only the fixed bits of a pattern
	localparam logic [7:0] MASK_GROUP = 8'hC0;
	localparam logic [7:0] MASK_MID   = 8'hC7;

	logic is_hlt;
	logic is_mov;
	logic is_mvi;
	logic is_alu;
	logic is_alui;
	logic is_jmp;
	logic is_jcc;
	logic cond;

	assign is_hlt  = ir == cpu8_pkg::OP_HLT;
	// HLT sits in the MOV group where MOV M,M would be
	assign is_mov  = (ir & MASK_GROUP) == cpu8_pkg::OP_MOV && !is_hlt;
	assign is_alu  = (ir & MASK_GROUP) == cpu8_pkg::OP_ALU;
	assign is_mvi  = (ir & MASK_MID) == cpu8_pkg::OP_MVI;
	assign is_alui = (ir & MASK_MID) == cpu8_pkg::OP_ALUI;
	assign is_jcc  = (ir & MASK_MID) == cpu8_pkg::OP_JCC;
	assign is_jmp  = ir == cpu8_pkg::OP_JMP;

	always_comb begin
		case (ir[5:3])
			cpu8_pkg::CC_NZ: cond = !flags[cpu8_pkg::FLAG_Z];
			cpu8_pkg::CC_Z:  cond = flags[cpu8_pkg::FLAG_Z];
			cpu8_pkg::CC_NC: cond = !flags[cpu8_pkg::FLAG_CY];
			cpu8_pkg::CC_C:  cond = flags[cpu8_pkg::FLAG_CY];
			cpu8_pkg::CC_PO: cond = !flags[cpu8_pkg::FLAG_P];
			cpu8_pkg::CC_PE: cond = flags[cpu8_pkg::FLAG_P];
			cpu8_pkg::CC_P:  cond = !flags[cpu8_pkg::FLAG_S];
			cpu8_pkg::CC_M:  cond = flags[cpu8_pkg::FLAG_S];
		endcase
	end

	always_comb begin
		if (is_hlt)
			decoded.iclass = cpu8_pkg::IC_HLT;
		else if (is_mov)
			decoded.iclass = cpu8_pkg::IC_MOV;
		else if (is_mvi)
			decoded.iclass = cpu8_pkg::IC_MVI;
		else if (is_alu)
			decoded.iclass = cpu8_pkg::IC_ALU;
		else if (is_alui)
			decoded.iclass = cpu8_pkg::IC_ALUI;
		else if (is_jmp)
			decoded.iclass = cpu8_pkg::IC_JMP;
		else if (is_jcc)
			decoded.iclass = cpu8_pkg::IC_JCC;
		else
			decoded.iclass = cpu8_pkg::IC_NOP;
		decoded.dst = cpu8_pkg::reg_sel_e'(ir[5:3]);
		decoded.src = cpu8_pkg::reg_sel_e'(ir[2:0]);
		decoded.alu_op = cpu8_pkg::alu_op_e'(ir[5:3]);
		// An unconditional jump always counts as taken
		decoded.cond_true = is_jmp || (is_jcc && cond);
	end

endmodule

// ==== design/register_file.sv ====
module register_file (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cpu8_pkg::reg_sel_e       src,
	output logic              [7:0]  rdata,
	input  cpu8_pkg::reg_sel_e       dst,
	input  logic                     we,
	input  logic              [7:0]  wdata,
	output logic              [7:0]  a_value,
	output logic              [15:0] hl
);

	// B, C, D, E, H and L in slots 0 to 5, A in slot 6
	logic [7:0] regs [7];
	logic [2:0] src_idx;
	logic [2:0] dst_idx;

	function automatic logic [2:0] slot(input cpu8_pkg::reg_sel_e sel);
		return (sel == cpu8_pkg::REG_A) ? 3'd6 : 3'(sel);
	endfunction

	assign src_idx = slot(src);
	assign dst_idx = slot(dst);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 7; i++) begin
				regs[i] <= 8'h00;
			end
		end else if (we && dst != cpu8_pkg::REG_M) begin
			regs[dst_idx] <= wdata;
		end
	end

	assign rdata = regs[src_idx];
	assign a_value = regs[6];
	assign hl = {regs[4], regs[5]};

	// The sequencer sends every M access to the memory bus instead
	a_no_m_write: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> dst != cpu8_pkg::REG_M);

endmodule

// ==== design/control_sequencer.sv ====
module control_sequencer #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  cpu8_pkg::decoded_t           decoded,
	input  cpu8_pkg::alu_result_t        alu_result,
	input  logic                  [7:0]  reg_rdata,
	input  logic                  [7:0]  a_value,
	input  logic                  [15:0] hl,
	input  logic                  [7:0]  memory_rdata,
	input  logic                         memory_done,
	output logic                  [7:0]  ir,
	output logic                  [7:0]  flags,
	output logic                  [7:0]  operand,
	output cpu8_pkg::alu_op_e            alu_op,
	output cpu8_pkg::reg_sel_e           reg_src,
	output cpu8_pkg::reg_sel_e           reg_dst,
	output logic                         reg_we,
	output logic                  [7:0]  reg_wdata,
	output cpu8_pkg::bus_req_t           bus,
	output logic                         halted,
	output logic                         fetch
);

	cpu8_pkg::cpu_state_e state;
	cpu8_pkg::cpu_state_e state_next;
	logic [15:0] pc;
	logic [7:0]  psr;
	logic        cycle_done;
	logic        dst_mem;
	logic        src_mem;
	logic        is_alui;

	assign dst_mem = decoded.dst == cpu8_pkg::REG_M;
	assign src_mem = decoded.src == cpu8_pkg::REG_M;
	assign is_alui = decoded.iclass == cpu8_pkg::IC_ALUI;
	// A state without a bus request finishes in one clock
	assign cycle_done = !(bus.read || bus.write) || memory_done;

	// ====================================================================
	// State sequence
	// ====================================================================

	always_comb begin
		state_next = cpu8_pkg::ST_FETCH;
		case (state)
			cpu8_pkg::ST_FETCH: state_next = cpu8_pkg::ST_DECODE;
			cpu8_pkg::ST_DECODE: begin
				case (decoded.iclass)
					cpu8_pkg::IC_MOV:  state_next = cpu8_pkg::ST_MOV;
					cpu8_pkg::IC_MVI:  state_next = cpu8_pkg::ST_MVI0;
					cpu8_pkg::IC_ALU,
					cpu8_pkg::IC_ALUI: state_next = cpu8_pkg::ST_ALU0;
					cpu8_pkg::IC_JMP,
					cpu8_pkg::IC_JCC:  state_next = cpu8_pkg::ST_JMP0;
					cpu8_pkg::IC_HLT:  state_next = cpu8_pkg::ST_HALT;
					default:           state_next = cpu8_pkg::ST_FETCH;
				endcase
			end
			cpu8_pkg::ST_MVI0: state_next = dst_mem ? cpu8_pkg::ST_MVI1 : cpu8_pkg::ST_FETCH;
			cpu8_pkg::ST_ALU0: state_next = cpu8_pkg::ST_ALU1;
			cpu8_pkg::ST_JMP0: state_next = cpu8_pkg::ST_JMP1;
			cpu8_pkg::ST_HALT: state_next = cpu8_pkg::ST_HALT;
			default:           state_next = cpu8_pkg::ST_FETCH;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cpu8_pkg::ST_FETCH;
			pc <= RESET_PC;
			ir <= 8'h00;
			psr <= cpu8_pkg::PSR_FIXED;
		end else if (cycle_done) begin
			state <= state_next;
			case (state)
				cpu8_pkg::ST_FETCH: begin
					ir <= memory_rdata;
					pc <= pc + 16'd1;
				end
				cpu8_pkg::ST_MVI0, cpu8_pkg::ST_JMP0: pc <= pc + 16'd1;
				cpu8_pkg::ST_ALU0: begin
					if (is_alui)
						pc <= pc + 16'd1;
				end
				// Not taken still steps past the high address byte
				cpu8_pkg::ST_JMP1: pc <= decoded.cond_true ? {memory_rdata, operand} : pc + 16'd1;
				cpu8_pkg::ST_ALU1: psr <= alu_result.flags | cpu8_pkg::PSR_FIXED;
				default: ;
			endcase
		end
	end

	// Holds the MVI byte, the ALU operand or the low jump address
	always_ff @(posedge clk) begin
		if (cycle_done) begin
			case (state)
				cpu8_pkg::ST_MVI0, cpu8_pkg::ST_JMP0: operand <= memory_rdata;
				cpu8_pkg::ST_ALU0: operand <= (is_alui || src_mem) ? memory_rdata : reg_rdata;
				default: ;
			endcase
		end
	end

	// ====================================================================
	// Bus requests and register file control
	// ====================================================================

	always_comb begin
		bus = '0;
		reg_we = 1'b0;
		reg_src = decoded.src;
		reg_dst = decoded.dst;
		reg_wdata = memory_rdata;
		case (state)
			cpu8_pkg::ST_FETCH, cpu8_pkg::ST_JMP0, cpu8_pkg::ST_JMP1: begin
				bus.read = 1'b1;
				bus.addr = pc;
			end
			cpu8_pkg::ST_MOV: begin
				bus.addr = hl;
				bus.wdata = reg_rdata;
				bus.read = src_mem;
				bus.write = dst_mem;
				reg_we = !dst_mem && cycle_done;
				reg_wdata = src_mem ? memory_rdata : reg_rdata;
			end
			cpu8_pkg::ST_MVI0: begin
				bus.read = 1'b1;
				bus.addr = pc;
				reg_we = !dst_mem && cycle_done;
			end
			cpu8_pkg::ST_MVI1: begin
				bus.write = 1'b1;
				bus.addr = hl;
				bus.wdata = operand;
			end
			cpu8_pkg::ST_ALU0: begin
				bus.read = is_alui || src_mem;
				bus.addr = is_alui ? pc : hl;
			end
			cpu8_pkg::ST_ALU1: begin
				// CMP writes A back unchanged so that only the flags move
				reg_we = 1'b1;
				reg_dst = cpu8_pkg::REG_A;
				reg_wdata = (decoded.alu_op == cpu8_pkg::ALU_CMP) ? a_value : alu_result.value;
			end
			default: ;
		endcase
	end

	assign alu_op = decoded.alu_op;
	assign flags = psr;
	assign halted = state == cpu8_pkg::ST_HALT;
	assign fetch = state == cpu8_pkg::ST_FETCH;

	a_bus_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(bus.read && bus.write));
	a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(bus.read || bus.write) && !memory_done
		|=> bus.read == $past(bus.read) && bus.write == $past(bus.write)
			&& $stable(bus.addr));
	a_halt_idle: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !bus.read && !bus.write);

endmodule

// ==== design/cpu8_top.sv ====
module cpu8_top #(
	parameter logic [15:0] RESET_PC = 16'h0000
) (
	input  logic        clk,
	input  logic        rst_n,
	output logic        memory_read,
	output logic        memory_write,
	output logic [15:0] memory_addr,
	output logic [7:0]  memory_wdata,
	input  logic [7:0]  memory_rdata,
	input  logic        memory_done,
	output logic        halted,
	output logic        fetch
);

	cpu8_pkg::decoded_t    decoded;
	cpu8_pkg::alu_result_t alu_result;
	cpu8_pkg::bus_req_t    bus;
	cpu8_pkg::alu_op_e     alu_op;
	cpu8_pkg::reg_sel_e    reg_src;
	cpu8_pkg::reg_sel_e    reg_dst;
	logic [7:0]  ir;
	logic [7:0]  flags;
	logic [7:0]  operand;
	logic [7:0]  reg_rdata;
	logic [7:0]  reg_wdata;
	logic [7:0]  a_value;
	logic [15:0] hl;
	logic        reg_we;

	control_sequencer #(
		.RESET_PC(RESET_PC)
	) u_seq (
		.clk(clk),
		.rst_n(rst_n),
		.decoded(decoded),
		.alu_result(alu_result),
		.reg_rdata(reg_rdata),
		.a_value(a_value),
		.hl(hl),
		.memory_rdata(memory_rdata),
		.memory_done(memory_done),
		.ir(ir),
		.flags(flags),
		.operand(operand),
		.alu_op(alu_op),
		.reg_src(reg_src),
		.reg_dst(reg_dst),
		.reg_we(reg_we),
		.reg_wdata(reg_wdata),
		.bus(bus),
		.halted(halted),
		.fetch(fetch)
	);

	instr_decoder u_dec (
		.ir(ir),
		.flags(flags),
		.decoded(decoded)
	);

	register_file u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.src(reg_src),
		.rdata(reg_rdata),
		.dst(reg_dst),
		.we(reg_we),
		.wdata(reg_wdata),
		.a_value(a_value),
		.hl(hl)
	);

	alu8 u_alu (
		.a(a_value),
		.b(operand),
		.carry_in(flags[cpu8_pkg::FLAG_CY]),
		.op(alu_op),
		.result(alu_result)
	);

	assign memory_read = bus.read;
	assign memory_write = bus.write;
	assign memory_addr = bus.addr;
	assign memory_wdata = bus.wdata;

endmodule

// ==== include/cpu8_ref.svh ====
`ifndef CPU8_REF_SVH
`define CPU8_REF_SVH

// Expected ALU result and flag byte, worked out in integer arithmetic
function automatic cpu8_pkg::alu_result_t ref_alu(input logic [7:0] a, input logic [7:0] b,
		input logic cy, input cpu8_pkg::alu_op_e op);
	int res;
	int lo;
	int c;
	cpu8_pkg::alu_result_t r;
	c = (op == cpu8_pkg::ALU_ADC || op == cpu8_pkg::ALU_SBB) ? int'(cy) : 0;
	r.flags = cpu8_pkg::PSR_FIXED;
	case (op)
		cpu8_pkg::ALU_ADD, cpu8_pkg::ALU_ADC: begin
			res = int'(a) + int'(b) + c;
			lo = int'(a[3:0]) + int'(b[3:0]) + c;
			r.flags[cpu8_pkg::FLAG_AC] = lo > 15;
			r.flags[cpu8_pkg::FLAG_CY] = res > 255;
		end
		cpu8_pkg::ALU_SUB, cpu8_pkg::ALU_SBB, cpu8_pkg::ALU_CMP: begin
			res = int'(a) - int'(b) - c;
			lo = int'(a[3:0]) - int'(b[3:0]) - c;
			r.flags[cpu8_pkg::FLAG_AC] = lo >= 0;
			r.flags[cpu8_pkg::FLAG_CY] = res < 0;
		end
		cpu8_pkg::ALU_AND: begin
			res = int'(a & b);
			r.flags[cpu8_pkg::FLAG_AC] = a[3] | b[3];
		end
		cpu8_pkg::ALU_XOR: res = int'(a ^ b);
		default: res = int'(a | b);
	endcase
	r.value = res[7:0];
	r.flags[cpu8_pkg::FLAG_S] = r.value[7];
	r.flags[cpu8_pkg::FLAG_Z] = r.value == 8'h00;
	r.flags[cpu8_pkg::FLAG_P] = ~^r.value;
	return r;
endfunction

// Whether a JCC with condition code cc is taken under the given flags
function automatic logic ref_cond(input logic [2:0] cc, input logic [7:0] flags);
	logic tested;
	case (cc[2:1])
		2'b00: tested = flags[cpu8_pkg::FLAG_Z];
		2'b01: tested = flags[cpu8_pkg::FLAG_CY];
		2'b10: tested = flags[cpu8_pkg::FLAG_P];
		default: tested = flags[cpu8_pkg::FLAG_S];
	endcase
	// Odd codes jump on a set flag
	return cc[0] ? tested : !tested;
endfunction

`endif

// ==== tb/cpu8_tb.sv ====
module cpu8_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [15:0] RESET_PC = 16'h0000;
	localparam int GROUPS = 24;
	localparam int GROUP_CYCLES = 300;
	// Extra room covers reset, the final moves and the quiet period after HLT
	localparam int TIMEOUT_CYCLES = GROUPS * GROUP_CYCLES + 2800;
	localparam logic [31:0] LFSR_SEED = 32'h8449_ab64;
	localparam logic [31:0] LFSR_POLY = 32'h8020_0003;
	localparam logic [15:0] SLOT_BASE = 16'h8000;
	localparam logic [15:0] FINAL_ADDR = 16'h9000;

	logic        clk = 1'b0;
	logic        rst_n = 1'b0;
	logic        memory_read;
	logic        memory_write;
	logic [15:0] memory_addr;
	logic [7:0]  memory_wdata;
	logic [7:0]  memory_rdata = 8'h00;
	logic        memory_done = 1'b0;
	logic        halted;
	logic        fetch;

	logic [7:0]  mem [65536];
	logic [31:0] lfsr = LFSR_SEED;
	logic [23:0] exp_q[$];
	string       exp_name[$];
	logic [23:0] seen_q[$];
	logic        bus_live = 1'b0;
	logic        busy = 1'b0;
	logic [7:0]  wait_left = 8'h00;
	logic [15:0] held_addr = 16'h0000;
	int          cycles = 0;
	int          fetch_count = 0;
	int          fetch_expected = 0;

	`include "cpu8_ref.svh"

	cpu8_top #(
		.RESET_PC(RESET_PC)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.memory_read(memory_read),
		.memory_write(memory_write),
		.memory_addr(memory_addr),
		.memory_wdata(memory_wdata),
		.memory_rdata(memory_rdata),
		.memory_done(memory_done),
		.halted(halted),
		.fetch(fetch)
	);

	always #10 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [23:0] expected,
			input logic [23:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_POLY) : (s >> 1);
	endfunction

	// One LFSR step per bit taken, first bit ends up as the MSB
	task automatic draw_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[6:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// ====================================================================
	// Program builder
	// ====================================================================

	function automatic logic [7:0] mvi_op(input cpu8_pkg::reg_sel_e r);
		return cpu8_pkg::OP_MVI | {2'b00, r, 3'b000};
	endfunction

	function automatic logic [7:0] mov_op(input cpu8_pkg::reg_sel_e d,
			input cpu8_pkg::reg_sel_e s);
		return cpu8_pkg::OP_MOV | {2'b00, d, s};
	endfunction

	task automatic emit(inout logic [15:0] at, input logic [7:0] value);
		mem[at] = value;
		at = at + 16'd1;
	endtask

	task automatic expect_write(input string name, input logic [15:0] addr,
			input logic [7:0] data);
		exp_name.push_back(name);
		exp_q.push_back({addr, data});
	endtask

	task automatic build_program();
		logic [15:0] at;
		logic [15:0] slot;
		logic [15:0] taken;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  bits;
		logic [7:0]  stored;
		logic [7:0]  psr;
		logic [2:0]  cc;
		logic        imm;
		logic        hit;
		cpu8_pkg::alu_op_e     op;
		cpu8_pkg::alu_result_t r;
		at = RESET_PC;
		psr = cpu8_pkg::PSR_FIXED;
		for (int g = 0; g < GROUPS; g++) begin
			draw_bits(8, a);
			draw_bits(8, b);
			draw_bits(3, bits);
			op = cpu8_pkg::alu_op_e'(bits[2:0]);
			draw_bits(1, bits);
			imm = bits[0];
			draw_bits(3, bits);
			cc = bits[2:0];
			slot = SLOT_BASE + 16'(2 * g);
			emit(at, mvi_op(cpu8_pkg::REG_A));
			emit(at, a);
			emit(at, mvi_op(cpu8_pkg::REG_B));
			emit(at, b);
			if (imm) begin
				emit(at, cpu8_pkg::OP_ALUI | {2'b00, op, 3'b000});
				emit(at, b);
			end else begin
				emit(at, cpu8_pkg::OP_ALU | {2'b00, op, cpu8_pkg::REG_B});
			end
			emit(at, mvi_op(cpu8_pkg::REG_H));
			emit(at, slot[15:8]);
			emit(at, mvi_op(cpu8_pkg::REG_L));
			emit(at, slot[7:0]);
			emit(at, mov_op(cpu8_pkg::REG_M, cpu8_pkg::REG_A));
			emit(at, mvi_op(cpu8_pkg::REG_L));
			emit(at, slot[7:0] + 8'd1);
			// JCC, MVI M,00h and JMP take eight bytes before the taken path
			taken = at + 16'd8;
			emit(at, cpu8_pkg::OP_JCC | {2'b00, cc, 3'b000});
			emit(at, taken[7:0]);
			emit(at, taken[15:8]);
			emit(at, mvi_op(cpu8_pkg::REG_M));
			emit(at, 8'h00);
			emit(at, cpu8_pkg::OP_JMP);
			emit(at, 8'(taken + 16'd2));
			emit(at, 8'((taken + 16'd2) >> 8));
			emit(at, mvi_op(cpu8_pkg::REG_M));
			emit(at, 8'h01);
			r = ref_alu(a, b, psr[cpu8_pkg::FLAG_CY], op);
			stored = (op == cpu8_pkg::ALU_CMP) ? a : r.value;
			psr = r.flags;
			hit = ref_cond(cc, psr);
			// Eight instructions up to the JCC, then one when taken or two when not
			fetch_expected = fetch_expected + (hit ? 9 : 10);
			expect_write($sformatf("group %0d %s result", g, op.name()), slot, stored);
			expect_write($sformatf("group %0d condition %0d marker", g, cc), slot + 16'd1,
				{7'd0, hit});
		end
		// Copy through C and E, then store E at the final address
		draw_bits(8, a);
		emit(at, mvi_op(cpu8_pkg::REG_C));
		emit(at, a);
		emit(at, mov_op(cpu8_pkg::REG_E, cpu8_pkg::REG_C));
		emit(at, mvi_op(cpu8_pkg::REG_H));
		emit(at, FINAL_ADDR[15:8]);
		emit(at, mvi_op(cpu8_pkg::REG_L));
		emit(at, FINAL_ADDR[7:0]);
		emit(at, mov_op(cpu8_pkg::REG_M, cpu8_pkg::REG_E));
		emit(at, cpu8_pkg::OP_HLT);
		fetch_expected = fetch_expected + 6;
		expect_write("register move", FINAL_ADDR, a);
	endtask

	// ====================================================================
	// Memory model, comparison and timeout
	// ====================================================================

	always @(posedge clk) bus_live <= rst_n;

	always @(negedge clk) begin
		memory_done = 1'b0;
		if (bus_live && (memory_read || memory_write)) begin
			if (!busy) begin
				busy = 1'b1;
				held_addr = memory_addr;
				draw_bits(2, wait_left);
			end
			check_value("address held while waiting", {8'h00, held_addr}, {8'h00, memory_addr});
			if (wait_left != 8'd0) begin
				wait_left = wait_left - 8'd1;
			end else begin
				busy = 1'b0;
				memory_done = 1'b1;
				if (memory_write) begin
					mem[memory_addr] = memory_wdata;
					seen_q.push_back({memory_addr, memory_wdata});
				end else begin
					memory_rdata = mem[memory_addr];
					if (fetch)
						fetch_count = fetch_count + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		logic [23:0] got;
		if (seen_q.size() != 0) begin
			got = seen_q.pop_front();
			if (exp_q.size() == 0)
				abort_run($sformatf("write of %h to address %h was never planned",
					got[7:0], got[23:8]));
			else
				check_value(exp_name.pop_front(), exp_q.pop_front(), got);
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES)
			abort_run($sformatf("the core never halted within %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8);
		build_program();
		repeat (2) @(negedge clk);
		// Fetch request at the reset address is already out during reset
		check_value("bus state in reset", 24'h000009,
			{20'd0, memory_read, memory_write, halted, fetch});
		check_value("fetch address in reset", {8'h00, RESET_PC}, {8'h00, memory_addr});
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		wait (halted === 1'b1);
		repeat (20) begin
			@(negedge clk);
			check_value("bus idle after halt", 24'h000002,
				{20'd0, memory_read, memory_write, halted, fetch});
		end
		check_value("instruction fetches", 24'(fetch_expected), 24'(fetch_count));
		if (exp_q.size() != 0 || seen_q.size() != 0) begin
			abort_run($sformatf("core halted with %0d planned writes missing", exp_q.size()));
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== build.f ====
+incdir+include
design/cpu8_pkg.sv
design/alu8.sv
design/instr_decoder.sv
design/register_file.sv
design/control_sequencer.sv
design/cpu8_top.sv
tb/cpu8_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := cpu8_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
